// File: dv/addrGenUnit_assert.sv
`timescale 1ns/1ps

module addrGenUnit_assert import lsuPkg::*; (
    input logic clk,
    input logic rst,
    input axiAr memAr,
    input logic memArReady,
    input aguOp ldOp,
    input aguOp stOp,
    input logic ldStall,
    input logic stStall,
    input branchProv branch
);

    int failures = 0;

    arHeld: assert property (@(posedge clk) disable iff (rst)
        memAr.arvalid && !memArReady |=> memAr.arvalid && $stable(memAr.araddr))
        else begin
            $error("arvalid dropped or araddr changed before arready");
            failures++;
        end

    quietInReset: assert property (@(posedge clk)
        rst && $past(rst) |-> !ldOp.valid && !stOp.valid && !memAr.arvalid)
        else begin
            $error("valid output high during reset");
            failures++;
        end

    ldOpStable: assert property (@(posedge clk) disable iff (rst)
        ldStall && ldOp.valid && !branch.taken |=> $stable(ldOp))
        else begin
            $error("load op changed under downstream stall");
            failures++;
        end

    stOpStable: assert property (@(posedge clk) disable iff (rst)
        stStall && stOp.valid && !branch.taken |=> $stable(stOp))
        else begin
            $error("store op changed under downstream stall");
            failures++;
        end

endmodule

bind addrGenUnit addrGenUnit_assert u_assert (
    .clk(clk),
    .rst(rst),
    .memAr(memAr),
    .memArReady(memArReady),
    .ldOp(ldOp),
    .stOp(stOp),
    .ldStall(ldStall),
    .stStall(stStall),
    .branch(branch)
);

// File: dv/pteMemModel.sv
`timescale 1ns/1ps

module pteMemModel import lsuPkg::*; (
    input  logic clk,
    input  logic rst,
    input  axiAr ar,
    input  logic rready,
    input  logic gate,
    output logic arReady,
    output axiR r
);

    // root table at ppn 0x80100, one level-0 table at ppn 0x80101
    function automatic logic [31:0] pteAt(logic [31:0] a);
        logic [31:0] pte;
        case (a)
            // vpn1 1 points to the level-0 table
            32'h8010_0004: pte = 32'h2004_0401;
            // vpn1 2 is a read/write superpage at ppn 0x80400
            32'h8010_0008: pte = 32'h2010_00c7;
            // read/write supervisor page
            32'h8010_1000: pte = 32'h2008_00c7;
            // read-only page
            32'h8010_1004: pte = 32'h2008_0443;
            // execute-only page
            32'h8010_1008: pte = 32'h2008_0849;
            // read/write user page
            32'h8010_1010: pte = 32'h2008_10d7;
            default: pte = 32'h0000_0000;
        endcase
        return pte;
    endfunction

    // random ready delay comes from the gate input, one read at a time
    assign arReady = ar.arvalid && gate && !r.rvalid;

    always_ff @(posedge clk) begin
        if (rst) begin
            r <= '0;
        end else begin
            if (r.rvalid && rready)
                r.rvalid <= 1'b0;
            if (ar.arvalid && arReady) begin
                r.rvalid <= 1'b1;
                r.rdata <= pteAt(ar.araddr);
                r.rresp <= respOkay;
            end
        end
    end

endmodule

// File: dv/tbAddrGenUnit.sv
`timescale 1ns/1ps

module tbAddrGenUnit import lsuPkg::*; ();

    typedef struct packed {
        logic sv32;
        logic [1:0] priv;
        logic mxr;
        lsuOpcode opc;
        logic [31:0] srcA;
        logic [11:0] imm;
        logic [31:0] srcB;
        logic flush;
        logic hit;
        logic [31:0] expAddr;
        aguExc expExc;
    } stimRow;

    logic clk;
    logic rst;
    vmemState vmem;
    branchProv branch;
    execUop ldUop;
    execUop stUop;
    logic ldStall;
    logic stStall;
    logic memArReady;
    axiR memR;
    logic ldReady;
    logic stReady;
    aguOp ldOp;
    aguOp stOp;
    axiAr memAr;
    logic memRready;
    logic memGate;
    logic [31:0] lfsr;
    stimRow rows [16];

    addrGenUnit u_dut (.*);

    pteMemModel u_mem (
        .clk(clk),
        .rst(rst),
        .ar(memAr),
        .rready(memRready),
        .gate(memGate),
        .arReady(memArReady),
        .r(memR)
    );

    always #2 clk = !clk;

    function automatic logic takeBit();
        lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
        return lfsr[0];
    endfunction

    always @(negedge clk) memGate <= takeBit();

    task automatic failRun(string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    always @(negedge clk) begin
        if (u_dut.u_assert.failures != 0)
            failRun("a concurrent assertion failed");
    end

    task automatic checkEq(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0.1f ns: %s got %h expected %h", $realtime, name, got, exp);
            failRun("value mismatch");
        end
    endtask

    task automatic waitReady(logic isSt);
        int n;
        n = 0;
        while (!(isSt ? stReady : ldReady)) begin
            @(posedge clk);
            #0.5;
            n++;
            if (n > 200)
                failRun("timeout while waiting for the AGU to become ready");
        end
    endtask

    // formatting rules for loads and stores
    function automatic aguOp expectedOp(stimRow s, execUop u, logic isSt);
        aguOp e;
        e = '0;
        e.valid = 1'b1;
        e.addr = s.expAddr;
        e.isLoad = !isSt;
        e.tagDst = isSt ? tagZero : u.tagDst;
        e.sqN = u.sqN;
        e.exc = s.expExc;
        e.size = (s.opc inside {opLb, opLbu, opSb}) ? 2'd0 :
                 (s.opc inside {opLh, opLhu, opSh}) ? 2'd1 : 2'd2;
        e.signExtend = s.opc == opLb || s.opc == opLh;
        if (isSt) begin
            if (e.size == 2'd0) begin
                e.wmask = 4'b0001 << s.expAddr[1:0];
                e.data = s.srcB << (8 * s.expAddr[1:0]);
            end else if (e.size == 2'd1) begin
                e.wmask = s.expAddr[1] ? 4'b1100 : 4'b0011;
                e.data = s.expAddr[1] ? s.srcB << 16 : s.srcB;
            end else begin
                e.wmask = 4'b1111;
                e.data = s.srcB;
            end
        end
        return e;
    endfunction

    task automatic checkOp(aguOp got, aguOp e);
        checkEq("op.addr", got.addr, e.addr);
        checkEq("op.data", got.data, e.data);
        checkEq("op.wmask", 32'(got.wmask), 32'(e.wmask));
        checkEq("op.size", 32'(got.size), 32'(e.size));
        checkEq("op.signExtend", 32'(got.signExtend), 32'(e.signExtend));
        checkEq("op.isLoad", 32'(got.isLoad), 32'(e.isLoad));
        checkEq("op.tagDst", 32'(got.tagDst), 32'(e.tagDst));
        checkEq("op.sqN", 32'(got.sqN), 32'(e.sqN));
        checkEq("op.exc", 32'(got.exc), 32'(e.exc));
    endtask

    task automatic runRow(int idx);
        stimRow s;
        execUop u;
        aguOp held;
        logic isSt;
        int cycles;
        int hold;
        s = rows[idx];
        isSt = s.opc inside {opSb, opSh, opSw};
        vmem.sv32en = s.sv32;
        vmem.priv = s.priv;
        vmem.makeExecReadable = s.mxr;
        u = '{1'b1, s.opc, s.srcA, s.srcB, s.imm, 7'(idx + 1), 8'(idx + 20)};
        if (isSt)
            stUop = u;
        else
            ldUop = u;
        waitReady(isSt);
        @(posedge clk);
        #0.5;
        ldUop.valid = 1'b0;
        stUop.valid = 1'b0;
        if (s.flush) begin
            // older branch cancels the walking op
            branch = '{1'b1, u.sqN - 8'd1};
            @(posedge clk);
            #0.5;
            branch.taken = 1'b0;
            cycles = 0;
            while (!(isSt ? stReady : ldReady) || cycles < 2) begin
                checkEq("op.valid", 32'(isSt ? stOp.valid : ldOp.valid), 32'd0);
                @(posedge clk);
                #0.5;
                cycles++;
                if (cycles > 200)
                    failRun("timeout while waiting for the flushed walk to drain");
            end
            checkEq("op.valid", 32'(isSt ? stOp.valid : ldOp.valid), 32'd0);
        end else begin
            cycles = 1;
            while (!(isSt ? stOp.valid : ldOp.valid)) begin
                @(posedge clk);
                #0.5;
                cycles++;
                if (cycles > 200)
                    failRun("timeout while waiting for op.valid");
            end
            if (s.hit)
                checkEq("latency", cycles, 1);
            held = isSt ? stOp : ldOp;
            checkOp(held, expectedOp(s, u, isSt));
            if (takeBit()) begin
                hold = {takeBit(), takeBit()} + 1;
                ldStall = !isSt;
                stStall = isSt;
                repeat (hold) begin
                    @(posedge clk);
                    #0.5;
                    checkEq("ready", 32'(isSt ? stReady : ldReady), 32'd0);
                    checkEq("op", (isSt ? stOp : ldOp) == held, 32'd1);
                end
                ldStall = 1'b0;
                stStall = 1'b0;
            end
        end
    endtask

    // both AGUs miss at once and share the walker
    task automatic runDualWalk();
        logic ldSeen;
        logic stSeen;
        int n;
        vmem.sv32en = 1'b1;
        vmem.priv = privUser;
        vmem.makeExecReadable = 1'b0;
        ldUop = '{1'b1, opLw, 32'h0040_4010, 32'h0, 12'h000, 7'h11, 8'h60};
        stUop = '{1'b1, opSw, 32'h0040_4020, 32'h1111_2222, 12'h000, 7'h12, 8'h61};
        waitReady(1'b0);
        waitReady(1'b1);
        @(posedge clk);
        #0.5;
        ldUop.valid = 1'b0;
        stUop.valid = 1'b0;
        ldSeen = 1'b0;
        stSeen = 1'b0;
        n = 0;
        while (!(ldSeen && stSeen)) begin
            if (ldOp.valid && !ldSeen) begin
                ldSeen = 1'b1;
                checkEq("ldOp.addr", ldOp.addr, 32'h8020_4010);
                checkEq("ldOp.exc", 32'(ldOp.exc), 32'(excNone));
            end
            if (stOp.valid && !stSeen) begin
                stSeen = 1'b1;
                checkEq("stOp.addr", stOp.addr, 32'h8020_4020);
                checkEq("stOp.exc", 32'(stOp.exc), 32'(excNone));
            end
            @(posedge clk);
            #0.5;
            n++;
            if (n > 200)
                failRun("timeout while waiting for both walks to finish");
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        lfsr = 32'd74432;
        memGate = 1'b0;
        vmem = '{1'b0, privSupervisor, 22'h080100, 1'b0, 1'b0};
        branch = '0;
        ldUop = '0;
        stUop = '0;
        ldStall = 1'b0;
        stStall = 1'b0;
        // bare mode
        rows[0] = '{0, privSupervisor, 0, opLw, 32'h8000_0100, 12'h004, 32'h0, 0, 1,
                    32'h8000_0104, excNone};
        rows[1] = '{0, privSupervisor, 0, opSb, 32'h8000_0200, 12'h003, 32'h0000_00a5, 0, 1,
                    32'h8000_0203, excNone};
        rows[2] = '{0, privSupervisor, 0, opSh, 32'h8000_0300, 12'hffe, 32'h0000_beef, 0, 1,
                    32'h8000_02fe, excNone};
        rows[3] = '{0, privSupervisor, 0, opLbu, 32'h8000_0001, 12'h000, 32'h0, 0, 1,
                    32'h8000_0001, excNone};
        rows[4] = '{0, privSupervisor, 0, opLh, 32'h8000_0010, 12'h002, 32'h0, 0, 1,
                    32'h8000_0012, excNone};
        rows[5] = '{0, privSupervisor, 0, opLw, 32'h0000_0001, 12'h000, 32'h0, 0, 1,
                    32'h0000_0001, excMisalign};
        rows[6] = '{0, privSupervisor, 0, opSw, 32'h9000_0000, 12'h000, 32'h0, 0, 1,
                    32'h9000_0000, excAccess};
        // Sv32 walks, hits and permission faults
        rows[7] = '{1, privSupervisor, 0, opLw, 32'h0040_0000, 12'h010, 32'h0, 0, 0,
                    32'h8020_0010, excNone};
        rows[8] = '{1, privSupervisor, 0, opLw, 32'h0040_0000, 12'h020, 32'h0, 0, 1,
                    32'h8020_0020, excNone};
        rows[9] = '{1, privSupervisor, 0, opSw, 32'h0080_1234, 12'h000, 32'h1234_5678, 0, 0,
                    32'h8040_1234, excNone};
        rows[10] = '{1, privSupervisor, 0, opSw, 32'h0040_1000, 12'h000, 32'h0, 0, 0,
                     32'h0040_1000, excPage};
        rows[11] = '{1, privSupervisor, 0, opLw, 32'h0040_2000, 12'h000, 32'h0, 0, 0,
                     32'h0040_2000, excPage};
        rows[12] = '{1, privSupervisor, 1, opLw, 32'h0040_2004, 12'h000, 32'h0, 0, 1,
                     32'h8020_2004, excNone};
        rows[13] = '{1, privSupervisor, 0, opLw, 32'h0040_3000, 12'h000, 32'h0, 0, 0,
                     32'h0040_3000, excPage};
        rows[14] = '{1, privUser, 0, opLw, 32'h0040_0000, 12'h000, 32'h0, 0, 1,
                     32'h0040_0000, excPage};
        rows[15] = '{1, privSupervisor, 0, opLw, 32'h00c0_0000, 12'h000, 32'h0, 1, 0,
                     32'h0, excNone};
        repeat (2) @(posedge clk);
        #0.5;
        rst = 1'b0;
        for (int i = 0; i < 16; i++)
            runRow(i);
        runDualWalk();
        if (u_dut.u_assert.failures == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            failRun("a concurrent assertion failed");
        end
    end

endmodule

// File: flist.f
hw/lsuPkg.sv
hw/dataTlb.sv
hw/pageWalker.sv
hw/agu.sv
hw/addrGenUnit.sv
dv/pteMemModel.sv
dv/addrGenUnit_assert.sv
dv/tbAddrGenUnit.sv

// File: hw/addrGenUnit.sv
`timescale 1ns/1ps

module addrGenUnit import lsuPkg::*; (
    input  logic clk,
    input  logic rst,
    input  vmemState vmem,
    input  branchProv branch,
    input  execUop ldUop,
    input  execUop stUop,
    input  logic ldStall,
    input  logic stStall,
    input  logic memArReady,
    input  axiR memR,
    output logic ldReady,
    output logic stReady,
    output aguOp ldOp,
    output aguOp stOp,
    output axiAr memAr,
    output logic memRready
);

    tlbReq ldTlbReq;
    tlbReq stTlbReq;
    tlbRes ldTlbRes;
    tlbRes stTlbRes;
    pwReq ldPwReq;
    pwReq stPwReq;
    pwRes walkRes;
    logic [19:0] fillVpn;
    logic ldAguStall;
    logic stAguStall;

    assign ldReady = !ldAguStall;
    assign stReady = !stAguStall;

    agu #(
        .isLoad(1'b1),
        .rqId(loadRqId)
    ) u_loadAgu (
        .clk(clk),
        .rst(rst),
        .en(1'b1),
        .vmem(vmem),
        .branch(branch),
        .uop(ldUop),
        .downStall(ldStall),
        .tlbRes(ldTlbRes),
        .pwRes(walkRes),
        .stall(ldAguStall),
        .tlbReq(ldTlbReq),
        .pwReq(ldPwReq),
        .op(ldOp)
    );

    agu #(
        .isLoad(1'b0),
        .rqId(storeRqId)
    ) u_storeAgu (
        .clk(clk),
        .rst(rst),
        .en(1'b1),
        .vmem(vmem),
        .branch(branch),
        .uop(stUop),
        .downStall(stStall),
        .tlbRes(stTlbRes),
        .pwRes(walkRes),
        .stall(stAguStall),
        .tlbReq(stTlbReq),
        .pwReq(stPwReq),
        .op(stOp)
    );

    dataTlb u_tlb (
        .clk(clk),
        .rst(rst),
        .vmem(vmem),
        .ldReq(ldTlbReq),
        .stReq(stTlbReq),
        .fill(walkRes),
        .fillVpn(fillVpn),
        .ldRes(ldTlbRes),
        .stRes(stTlbRes)
    );

    pageWalker u_walker (
        .clk(clk),
        .rst(rst),
        .vmem(vmem),
        .ldReq(ldPwReq),
        .stReq(stPwReq),
        .memArReady(memArReady),
        .memR(memR),
        .res(walkRes),
        .fillVpn(fillVpn),
        .memAr(memAr),
        .memRready(memRready)
    );

endmodule

// File: hw/agu.sv
`timescale 1ns/1ps

module agu import lsuPkg::*; #(
    parameter bit isLoad = 1'b1,
    parameter logic rqId = loadRqId
) (
    input  logic clk,
    input  logic rst,
    input  logic en,
    input  vmemState vmem,
    input  branchProv branch,
    input  execUop uop,
    input  logic downStall,
    input  lsuPkg::tlbRes tlbRes,
    input  lsuPkg::pwRes pwRes,
    output logic stall,
    output lsuPkg::tlbReq tlbReq,
    output lsuPkg::pwReq pwReq,
    output aguOp op
);

    typedef enum logic [1:0] {
        walkIdle,
        walkActive,
        walkAccepted,
        walkCancel
    } walkState;

    walkState state;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] phyAddr;
    logic [xlen-1:0] walkAddr;
    logic uopFlushed;
    logic opFlushed;
    logic accept;
    logic needWalk;
    aguExc exc;
    aguExc walkExc;
    aguOp nextOp;

    function automatic logic legalAddr(logic [xlen-1:0] a);
        return a >= legalAddrLo && a <= legalAddrHi;
    endfunction

    function automatic logic permFault(logic [2:0] rwx, logic user);
        logic fault;
        if (isLoad)
            fault = !(rwx[2] || (rwx[0] && vmem.makeExecReadable));
        else
            fault = !rwx[1];
        if (vmem.priv == privUser && !user)
            fault = 1'b1;
        if (vmem.priv == privSupervisor && user && !vmem.supervUserMemory)
            fault = 1'b1;
        return fault;
    endfunction

    assign addr = uop.srcA + {{20{uop.imm[11]}}, uop.imm};
    assign phyAddr = vmem.sv32en ? {tlbRes.ppn[19:0], addr[11:0]} : addr;

    // younger than the mispredicted branch
    assign uopFlushed = branch.taken && $signed(uop.sqN - branch.sqN) > 0;
    assign opFlushed = branch.taken && $signed(op.sqN - branch.sqN) > 0;

    assign stall = downStall || state != walkIdle;
    assign accept = en && uop.valid && !stall && !uopFlushed;

    assign tlbReq.valid = vmem.sv32en && en && uop.valid && !stall;
    assign tlbReq.vpn = addr[31:12];

    always_comb begin
        exc = excNone;
        if (vmem.sv32en && tlbRes.hit && permFault(tlbRes.rwx, tlbRes.user)) begin
            exc = excPage;
        end else if (!(vmem.sv32en && !tlbRes.hit) &&
                     (!legalAddr(phyAddr) || (vmem.sv32en && tlbRes.ppn[21:20] != 2'b00))) begin
            exc = excAccess;
        end
        // misalignment wins over both faults
        case (uop.opcode)
            opLh, opLhu, opSh: begin
                if (addr[0])
                    exc = excMisalign;
            end
            opLw, opSw: begin
                if (addr[1:0] != 2'b00)
                    exc = excMisalign;
            end
            default: begin
            end
        endcase
    end

    assign needWalk = vmem.sv32en && !tlbRes.hit && exc == excNone;

    always_comb begin
        nextOp = '0;
        nextOp.valid = !needWalk;
        // faulting and walking ops keep the virtual address
        nextOp.addr = (vmem.sv32en && tlbRes.hit && exc == excNone) ? phyAddr : addr;
        nextOp.isLoad = isLoad;
        nextOp.tagDst = isLoad ? uop.tagDst : tagZero;
        nextOp.sqN = uop.sqN;
        nextOp.exc = exc;
        if (isLoad) begin
            nextOp.signExtend = uop.opcode == opLb || uop.opcode == opLh;
            case (uop.opcode)
                opLb, opLbu: nextOp.size = 2'd0;
                opLh, opLhu: nextOp.size = 2'd1;
                default: nextOp.size = 2'd2;
            endcase
        end else begin
            case (uop.opcode)
                opSb: begin
                    nextOp.size = 2'd0;
                    nextOp.wmask = 4'b0001 << addr[1:0];
                    nextOp.data = uop.srcB << {addr[1:0], 3'b000};
                end
                opSh: begin
                    nextOp.size = 2'd1;
                    nextOp.wmask = addr[1] ? 4'b1100 : 4'b0011;
                    nextOp.data = addr[1] ? uop.srcB << 16 : uop.srcB;
                end
                default: begin
                    nextOp.size = 2'd2;
                    nextOp.wmask = 4'b1111;
                    nextOp.data = uop.srcB;
                end
            endcase
        end
    end

    // op.addr holds the virtual address while a walk is in flight
    assign walkAddr = pwRes.superPage ? {pwRes.ppn[19:10], op.addr[21:0]} :
                                        {pwRes.ppn[19:0], op.addr[11:0]};

    always_comb begin
        walkExc = excNone;
        if (pwRes.pageFault || permFault(pwRes.rwx, pwRes.user))
            walkExc = excPage;
        else if (pwRes.ppn[21:20] != 2'b00 || !legalAddr(walkAddr))
            walkExc = excAccess;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= walkIdle;
            op.valid <= 1'b0;
            pwReq.valid <= 1'b0;
        end else begin
            case (state)
                walkIdle: begin
                    if (accept) begin
                        op <= nextOp;
                        if (needWalk) begin
                            state <= walkActive;
                            pwReq.valid <= 1'b1;
                            pwReq.vaddr <= addr;
                        end
                    end else if (!downStall || opFlushed) begin
                        op.valid <= 1'b0;
                    end
                end
                walkActive: begin
                    if (opFlushed) begin
                        state <= walkCancel;
                        pwReq.valid <= 1'b0;
                    end else if (pwRes.busy && pwRes.rqId == rqId) begin
                        state <= walkAccepted;
                        pwReq.valid <= 1'b0;
                    end
                end
                walkAccepted: begin
                    if (opFlushed) begin
                        state <= walkCancel;
                    end else if (pwRes.valid && pwRes.rqId == rqId) begin
                        state <= walkIdle;
                        op.valid <= 1'b1;
                        op.exc <= walkExc;
                        if (walkExc == excNone)
                            op.addr <= walkAddr;
                    end
                end
                default: begin
                    // walker may still be reading for the dropped op
                    if (!pwRes.busy || pwRes.rqId != rqId)
                        state <= walkIdle;
                end
            endcase
        end
    end

endmodule

// File: hw/dataTlb.sv
`timescale 1ns/1ps

module dataTlb import lsuPkg::*; (
    input  logic clk,
    input  logic rst,
    input  vmemState vmem,
    input  tlbReq ldReq,
    input  tlbReq stReq,
    input  pwRes fill,
    input  logic [19:0] fillVpn,
    output tlbRes ldRes,
    output tlbRes stRes
);

    logic [tlbEntries-1:0] entValid;
    logic [tlbEntries-1:0] entUser;
    logic [tlbEntries-1:0] entSuper;
    logic [19:0] entVpn [tlbEntries];
    logic [21:0] entPpn [tlbEntries];
    logic [2:0] entRwx [tlbEntries];
    logic [$clog2(tlbEntries)-1:0] victim;
    logic fillEn;

    function automatic tlbRes lookup(tlbReq req);
        tlbRes res;
        res = '0;
        for (int i = 0; i < tlbEntries; i++) begin
            // superpage entries ignore the low ten vpn bits
            if (!res.hit && entValid[i] && entVpn[i][19:10] == req.vpn[19:10] &&
                (entSuper[i] || entVpn[i][9:0] == req.vpn[9:0])) begin
                res.hit = 1'b1;
                res.rwx = entRwx[i];
                res.user = entUser[i];
                res.superPage = entSuper[i];
                if (entSuper[i])
                    res.ppn = {entPpn[i][21:10], req.vpn[9:0]};
                else
                    res.ppn = entPpn[i];
            end
        end
        res.hit = res.hit && req.valid && vmem.sv32en;
        return res;
    endfunction

    always_comb begin
        ldRes = lookup(ldReq);
        stRes = lookup(stReq);
    end

    // faulting walks are never cached
    assign fillEn = fill.valid && !fill.pageFault && vmem.sv32en;

    always_ff @(posedge clk) begin
        if (rst) begin
            entValid <= '0;
            victim <= '0;
        end else if (fillEn) begin
            entValid[victim] <= 1'b1;
            victim <= victim + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fillEn) begin
            entVpn[victim] <= fillVpn;
            entPpn[victim] <= fill.ppn;
            entRwx[victim] <= fill.rwx;
            entUser[victim] <= fill.user;
            entSuper[victim] <= fill.superPage;
        end
    end

endmodule

// File: hw/lsuPkg.sv
package lsuPkg;

    localparam int xlen = 32;
    localparam int tlbEntries = 4;

    // inclusive window of physical memory that may be accessed
    localparam logic [xlen-1:0] legalAddrLo = 32'h8000_0000;
    localparam logic [xlen-1:0] legalAddrHi = 32'h8fff_ffff;

    localparam logic [1:0] privUser = 2'd0;
    localparam logic [1:0] privSupervisor = 2'd1;

    localparam logic loadRqId = 1'b0;
    localparam logic storeRqId = 1'b1;

    // destination tag for ops that write no register
    localparam logic [6:0] tagZero = 7'h40;

    localparam logic [1:0] respOkay = 2'b00;

    typedef enum logic [3:0] {
        opLb,
        opLh,
        opLw,
        opLbu,
        opLhu,
        opSb,
        opSh,
        opSw
    } lsuOpcode;

    typedef enum logic [1:0] {
        excNone,
        excMisalign,
        excAccess,
        excPage
    } aguExc;

    typedef struct packed {
        logic valid;
        lsuOpcode opcode;
        logic [xlen-1:0] srcA;
        logic [xlen-1:0] srcB;
        logic [11:0] imm;
        logic [6:0] tagDst;
        logic [7:0] sqN;
    } execUop;

    typedef struct packed {
        logic taken;
        logic [7:0] sqN;
    } branchProv;

    typedef struct packed {
        logic sv32en;
        logic [1:0] priv;
        logic [21:0] rootPpn;
        logic supervUserMemory;
        logic makeExecReadable;
    } vmemState;

    typedef struct packed {
        logic valid;
        logic [19:0] vpn;
    } tlbReq;

    // ppn is final, superpages already merged with the low vpn bits
    typedef struct packed {
        logic hit;
        logic [21:0] ppn;
        logic [2:0] rwx;
        logic user;
        logic superPage;
    } tlbRes;

    typedef struct packed {
        logic valid;
        logic [xlen-1:0] vaddr;
    } pwReq;

    typedef struct packed {
        logic valid;
        logic busy;
        logic rqId;
        logic pageFault;
        logic [21:0] ppn;
        logic [2:0] rwx;
        logic user;
        logic superPage;
    } pwRes;

    typedef struct packed {
        logic valid;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] data;
        logic [3:0] wmask;
        logic [1:0] size;
        logic signExtend;
        logic isLoad;
        logic [6:0] tagDst;
        logic [7:0] sqN;
        aguExc exc;
    } aguOp;

    typedef struct packed {
        logic [xlen-1:0] araddr;
        logic arvalid;
    } axiAr;

    typedef struct packed {
        logic [xlen-1:0] rdata;
        logic [1:0] rresp;
        logic rvalid;
    } axiR;

    typedef struct packed {
        logic [21:0] ppn;
        logic [1:0] rsw;
        logic d;
        logic a;
        logic g;
        logic u;
        logic x;
        logic w;
        logic r;
        logic v;
    } pteFields;

    typedef union packed {
        logic [31:0] raw;
        pteFields fields;
    } pteWord;

endpackage

// File: hw/pageWalker.sv
`timescale 1ns/1ps

module pageWalker import lsuPkg::*; (
    input  logic clk,
    input  logic rst,
    input  vmemState vmem,
    input  pwReq ldReq,
    input  pwReq stReq,
    input  logic memArReady,
    input  axiR memR,
    output pwRes res,
    output logic [19:0] fillVpn,
    output axiAr memAr,
    output logic memRready
);

    typedef enum logic [1:0] {
        phIdle,
        phAddr,
        phData,
        phDone
    } walkPhase;

    walkPhase phase;
    logic level;
    logic curRq;
    logic [xlen-1:0] vaddr;
    logic [xlen-1:0] araddr;
    logic resFault;
    logic [21:0] resPpn;
    logic [2:0] resRwx;
    logic resUser;
    logic resSuper;
    pteWord pte;
    logic pteOk;
    logic isLeaf;

    assign pte.raw = memR.rdata;
    assign isLeaf = pte.fields.r || pte.fields.x;
    // w without r is reserved
    assign pteOk = memR.rresp == respOkay && pte.fields.v && !(pte.fields.w && !pte.fields.r);

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= phIdle;
        end else begin
            case (phase)
                phIdle: begin
                    // load side wins ties
                    if (ldReq.valid || stReq.valid) begin
                        phase <= phAddr;
                        level <= 1'b1;
                        curRq <= ldReq.valid ? loadRqId : storeRqId;
                        vaddr <= ldReq.valid ? ldReq.vaddr : stReq.vaddr;
                        if (ldReq.valid)
                            araddr <= {vmem.rootPpn[19:0], ldReq.vaddr[31:22], 2'b00};
                        else
                            araddr <= {vmem.rootPpn[19:0], stReq.vaddr[31:22], 2'b00};
                    end
                end
                phAddr: begin
                    if (memArReady)
                        phase <= phData;
                end
                phData: begin
                    if (memR.rvalid) begin
                        phase <= phDone;
                        resFault <= 1'b1;
                        resPpn <= pte.fields.ppn;
                        resRwx <= {pte.fields.r, pte.fields.w, pte.fields.x};
                        resUser <= pte.fields.u;
                        resSuper <= level;
                        if (pteOk) begin
                            if (isLeaf) begin
                                // a superpage must be 4 MiB aligned
                                resFault <= level && pte.fields.ppn[9:0] != 10'd0;
                            end else if (level) begin
                                level <= 1'b0;
                                araddr <= {pte.fields.ppn[19:0], vaddr[21:12], 2'b00};
                                phase <= phAddr;
                            end
                        end
                    end
                end
                default: begin
                    phase <= phIdle;
                end
            endcase
        end
    end

    always_comb begin
        res.valid = phase == phDone;
        res.busy = phase != phIdle;
        res.rqId = curRq;
        res.pageFault = resFault;
        res.ppn = resPpn;
        res.rwx = resRwx;
        res.user = resUser;
        res.superPage = resSuper;
    end

    assign fillVpn = vaddr[31:12];
    assign memAr.araddr = araddr;
    assign memAr.arvalid = phase == phAddr;
    assign memRready = phase == phData;

endmodule
